//--- hw/render_consts.svh
`ifndef RENDER_CONSTS_SVH
`define RENDER_CONSTS_SVH

// Memory bus geometry
`define BUS_ADDR_W      15
`define BUS_DATA_W      32

// Pixels written per scan line
`define LINE_PIXELS     640

// Map is square, 32 entries a side
`define MAP_COLS_LOG2   5

// Tiles are 8x8, so rows and columns share this value
`define TILE_ROWS_LOG2  3

`define TILE_IDX_W      10

// Base registers count in units of 128 words
`define BASE_SHIFT      7

`define LB_IDX_W        10

`endif

//--- hw/bus_pkg.sv
`default_nettype none

`include "render_consts.svh"

package bus_pkg;

    // Word address into the 32-bit memory
    typedef logic [`BUS_ADDR_W-1:0] bus_addr_t;

    typedef logic [`BUS_DATA_W-1:0] bus_data_t;

endpackage

`default_nettype wire

//--- hw/layer_pkg.sv
`default_nettype none

`include "render_consts.svh"

package layer_pkg;

    //////////////////////////////////////////////////////////////////////
    // Layer configuration
    //////////////////////////////////////////////////////////////////////

    typedef enum logic {
        depth_4bpp = 1'b0,
        depth_8bpp = 1'b1
    } color_depth_t;

    //////////////////////////////////////////////////////////////////////
    // Map and pixel data
    //////////////////////////////////////////////////////////////////////

    // One 16-bit map entry, two of them per bus word
    typedef struct packed {
        logic [3:0]            palette;
        logic                  vflip;
        logic                  hflip;
        logic [`TILE_IDX_W-1:0] tile_idx;
    } map_entry_t;

    // Colour index as written to the line buffer
    typedef logic [7:0] pixel_t;

endpackage

`default_nettype wire

//--- hw/tile_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "render_consts.svh"

module tile_addr_gen (
    input  wire [8:0]                    line_idx,
    input  wire layer_pkg::color_depth_t color_depth,
    input  wire [7:0]                    map_baseaddr,
    input  wire [7:0]                    tile_baseaddr,
    input  wire [`MAP_COLS_LOG2-1:0]     tile_col,
    input  wire                          word_num,
    input  wire bus_pkg::bus_data_t      map_word,
    output bus_pkg::bus_addr_t           map_addr,
    output bus_pkg::bus_addr_t           tile_addr,
    output layer_pkg::map_entry_t        cur_entry
);

    logic [`MAP_COLS_LOG2-1:0]   map_row;
    logic [2*`MAP_COLS_LOG2-1:0] map_idx;
    logic [`TILE_ROWS_LOG2-1:0]  tile_row;
    logic                        word_sel;
    bus_pkg::bus_addr_t          map_base;
    bus_pkg::bus_addr_t          tile_base;
    bus_pkg::bus_addr_t          tile_off;

    // Map row wraps with the line, since only the low row bits are kept
    assign map_row = line_idx[`TILE_ROWS_LOG2 +: `MAP_COLS_LOG2];
    assign map_idx = {map_row, tile_col};

    assign map_base  = bus_pkg::bus_addr_t'({map_baseaddr, {`BASE_SHIFT{1'b0}}});
    assign tile_base = bus_pkg::bus_addr_t'({tile_baseaddr, {`BASE_SHIFT{1'b0}}});

    // Two entries per word, odd column in the upper half
    assign map_addr  = map_base + bus_pkg::bus_addr_t'(map_idx[2*`MAP_COLS_LOG2-1:1]);
    assign cur_entry = layer_pkg::map_entry_t'(tile_col[0] ? map_word[31:16] : map_word[15:0]);

    // V-flip picks the mirrored row, H-flip swaps the two 8 bpp words
    assign tile_row = cur_entry.vflip ? ~line_idx[`TILE_ROWS_LOG2-1:0]
                                      : line_idx[`TILE_ROWS_LOG2-1:0];
    assign word_sel = cur_entry.hflip ^ word_num;

    always_comb begin
        if (color_depth == layer_pkg::depth_8bpp) begin
            // 16 words per tile, 2 per row
            tile_off = bus_pkg::bus_addr_t'({cur_entry.tile_idx, tile_row, word_sel});
        end else begin
            // 8 words per tile, 1 per row
            tile_off = bus_pkg::bus_addr_t'({cur_entry.tile_idx, tile_row});
        end
    end

    assign tile_addr = tile_base + tile_off;

endmodule

`default_nettype wire

//--- hw/tile_fetcher.sv
`timescale 1ns/1ps
`default_nettype none

`include "render_consts.svh"

module tile_fetcher (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          line_render_start,
    input  wire layer_pkg::color_depth_t color_depth,
    input  wire bus_pkg::bus_data_t      bus_rddata,
    input  wire                          bus_ack,
    input  wire layer_pkg::map_entry_t   cur_entry,
    input  wire bus_pkg::bus_addr_t      map_addr,
    input  wire bus_pkg::bus_addr_t      tile_addr,
    input  wire                          word_ack,
    output logic [`MAP_COLS_LOG2-1:0]    tile_col,
    output logic                         word_num,
    output bus_pkg::bus_data_t           map_word,
    output bus_pkg::bus_addr_t           bus_addr,
    output logic                         bus_strobe,
    output logic                         word_req,
    output bus_pkg::bus_data_t           word_data,
    output logic [3:0]                   word_palette,
    output logic                         word_hflip
);

    // Tiles are as wide as they are tall
    localparam logic [6:0] last_tile = 7'((`LINE_PIXELS >> `TILE_ROWS_LOG2) - 1);

    typedef enum logic [2:0] {
        st_idle,
        st_fetch_map,
        st_wait_map,
        st_fetch_tile,
        st_wait_tile,
        st_handover
    } state_t;

    state_t             state;
    logic               strobe_r;
    logic               restart_pending;
    logic [6:0]         tile_cnt;
    bus_pkg::bus_data_t tile_buf;
    logic               word_free;
    logic               last_word;
    logic               fetch_state;

    // Strobe falls in the ack cycle itself
    assign bus_strobe = strobe_r && !bus_ack;

    assign tile_col = tile_cnt[`MAP_COLS_LOG2-1:0];

    // Previous four-phase exchange fully closed
    assign word_free   = !word_req && !word_ack && !line_render_start;
    assign last_word   = (color_depth == layer_pkg::depth_4bpp) || word_num;
    assign fetch_state = (state == st_fetch_map) || (state == st_fetch_tile);

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state           <= st_idle;
            strobe_r        <= 1'b0;
            restart_pending <= 1'b0;
            tile_cnt        <= '0;
            word_num        <= 1'b0;
            word_req        <= 1'b0;
        end else begin
            if (word_req && word_ack) begin
                word_req <= 1'b0;
            end

            case (state)
                st_idle: begin
                end
                st_fetch_map: begin
                    strobe_r <= 1'b1;
                    state    <= st_wait_map;
                end
                st_wait_map: begin
                    if (bus_ack) begin
                        strobe_r        <= 1'b0;
                        restart_pending <= 1'b0;
                        state           <= restart_pending ? st_fetch_map : st_fetch_tile;
                    end
                end
                st_fetch_tile: begin
                    strobe_r <= 1'b1;
                    state    <= st_wait_tile;
                end
                st_wait_tile: begin
                    if (bus_ack) begin
                        strobe_r        <= 1'b0;
                        restart_pending <= 1'b0;
                        state           <= restart_pending ? st_fetch_map : st_handover;
                    end
                end
                st_handover: begin
                    if (word_free) begin
                        word_req <= 1'b1;
                        if (!last_word) begin
                            word_num <= 1'b1;
                            state    <= st_fetch_tile;
                        end else begin
                            word_num <= 1'b0;
                            tile_cnt <= tile_cnt + 7'd1;
                            if (tile_cnt == last_tile) begin
                                state <= st_idle;
                            end else if (tile_col[0]) begin
                                // Both entries of this map word used up
                                state <= st_fetch_map;
                            end else begin
                                state <= st_fetch_tile;
                            end
                        end
                    end
                end
                default: state <= st_idle;
            endcase

            // A bus cycle in progress is allowed to finish and its data dropped
            if (line_render_start) begin
                tile_cnt <= '0;
                word_num <= 1'b0;
                if (fetch_state || (strobe_r && !bus_ack)) begin
                    restart_pending <= 1'b1;
                end else begin
                    state <= st_fetch_map;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Data path
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == st_fetch_map) begin
            bus_addr <= map_addr;
        end else if (state == st_fetch_tile) begin
            bus_addr <= tile_addr;
        end

        if (state == st_wait_map && bus_ack) begin
            map_word <= bus_rddata;
        end
        if (state == st_wait_tile && bus_ack) begin
            tile_buf <= bus_rddata;
        end

        // Entry still selected by the current column
        if (state == st_handover && word_free) begin
            word_data    <= tile_buf;
            word_palette <= cur_entry.palette;
            word_hflip   <= cur_entry.hflip;
        end
    end

endmodule

`default_nettype wire

//--- hw/pixel_serializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "render_consts.svh"

module pixel_serializer (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          line_render_start,
    input  wire layer_pkg::color_depth_t color_depth,
    input  wire                          word_req,
    input  wire bus_pkg::bus_data_t      word_data,
    input  wire [3:0]                    word_palette,
    input  wire                          word_hflip,
    output logic                         word_ack,
    output logic [`LB_IDX_W-1:0]         linebuf_wridx,
    output layer_pkg::pixel_t            linebuf_wrdata,
    output logic                         linebuf_wren
);

    logic                 busy;
    logic [2:0]           pix_cnt;
    logic [`LB_IDX_W-1:0] lb_idx;
    bus_pkg::bus_data_t   cur_data;
    logic [3:0]           cur_palette;
    logic                 cur_hflip;
    logic [2:0]           pix_x;
    logic [7:0]           sel_byte;
    layer_pkg::pixel_t    raw_pix;
    layer_pkg::pixel_t    out_pix;
    logic                 pix_last;
    logic                 line_full;
    logic                 emit;
    logic                 take;

    //////////////////////////////////////////////////////////////////////
    // Pixel extraction
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        pix_x = cur_hflip ? ~pix_cnt : pix_cnt;
        if (color_depth == layer_pkg::depth_8bpp) begin
            sel_byte = cur_data[{pix_x[1:0], 3'b000} +: 8];
            raw_pix  = sel_byte;
        end else begin
            // Even pixel in the high nibble
            sel_byte = cur_data[{pix_x[2:1], 3'b000} +: 8];
            raw_pix  = {4'b0000, pix_x[0] ? sel_byte[3:0] : sel_byte[7:4]};
        end

        // Palette offset only for the low 15 colours
        if (raw_pix[7:4] == 4'd0 && raw_pix[3:0] != 4'd0) begin
            out_pix = {cur_palette, raw_pix[3:0]};
        end else begin
            out_pix = raw_pix;
        end
    end

    assign pix_last  = (color_depth == layer_pkg::depth_8bpp) ? (pix_cnt == 3'd3)
                                                               : (pix_cnt == 3'd7);
    assign line_full = (lb_idx == `LB_IDX_W'(`LINE_PIXELS));
    assign emit      = busy && !line_full && !line_render_start;

    // Next word may be taken in the cycle of the last pixel
    assign take = word_req && !word_ack && !line_render_start
                  && (!busy || (emit && pix_last));

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy         <= 1'b0;
            pix_cnt      <= '0;
            lb_idx       <= '0;
            word_ack     <= 1'b0;
            linebuf_wren <= 1'b0;
        end else begin
            linebuf_wren <= emit;

            if (word_ack && !word_req) begin
                word_ack <= 1'b0;
            end

            if (emit) begin
                lb_idx  <= lb_idx + `LB_IDX_W'(1);
                pix_cnt <= pix_cnt + 3'd1;
            end
            if (busy && (line_full || pix_last)) begin
                busy    <= 1'b0;
                pix_cnt <= '0;
            end

            if (take) begin
                busy     <= 1'b1;
                pix_cnt  <= '0;
                word_ack <= 1'b1;
            end

            if (line_render_start) begin
                busy    <= 1'b0;
                pix_cnt <= '0;
                lb_idx  <= '0;
                // Word of the old line closed out, its data thrown away
                if (word_req && !word_ack) begin
                    word_ack <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Data path
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (take) begin
            cur_data    <= word_data;
            cur_palette <= word_palette;
            cur_hflip   <= word_hflip;
        end
        if (emit) begin
            linebuf_wridx  <= lb_idx;
            linebuf_wrdata <= out_pix;
        end
    end

endmodule

`default_nettype wire

//--- hw/layer_renderer.sv
`timescale 1ns/1ps
`default_nettype none

`include "render_consts.svh"

module layer_renderer (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          line_render_start,
    input  wire [8:0]                    line_idx,
    input  wire layer_pkg::color_depth_t color_depth,
    input  wire [7:0]                    map_baseaddr,
    input  wire [7:0]                    tile_baseaddr,
    input  wire bus_pkg::bus_data_t      bus_rddata,
    input  wire                          bus_ack,
    output bus_pkg::bus_addr_t           bus_addr,
    output logic                         bus_strobe,
    output logic [`LB_IDX_W-1:0]         linebuf_wridx,
    output layer_pkg::pixel_t            linebuf_wrdata,
    output logic                         linebuf_wren
);

    // Address generator <-> fetcher
    bus_pkg::bus_addr_t        map_addr;
    bus_pkg::bus_addr_t        tile_addr;
    layer_pkg::map_entry_t     cur_entry;
    logic [`MAP_COLS_LOG2-1:0] tile_col;
    logic                      word_num;
    bus_pkg::bus_data_t        map_word;

    // Fetcher -> serializer word handshake
    logic                      word_req;
    logic                      word_ack;
    bus_pkg::bus_data_t        word_data;
    logic [3:0]                word_palette;
    logic                      word_hflip;

    tile_addr_gen i_tile_addr_gen (
        .line_idx      (line_idx),
        .color_depth   (color_depth),
        .map_baseaddr  (map_baseaddr),
        .tile_baseaddr (tile_baseaddr),
        .tile_col      (tile_col),
        .word_num      (word_num),
        .map_word      (map_word),
        .map_addr      (map_addr),
        .tile_addr     (tile_addr),
        .cur_entry     (cur_entry)
    );

    tile_fetcher i_tile_fetcher (
        .clk               (clk),
        .rst               (rst),
        .line_render_start (line_render_start),
        .color_depth       (color_depth),
        .bus_rddata        (bus_rddata),
        .bus_ack           (bus_ack),
        .cur_entry         (cur_entry),
        .map_addr          (map_addr),
        .tile_addr         (tile_addr),
        .word_ack          (word_ack),
        .tile_col          (tile_col),
        .word_num          (word_num),
        .map_word          (map_word),
        .bus_addr          (bus_addr),
        .bus_strobe        (bus_strobe),
        .word_req          (word_req),
        .word_data         (word_data),
        .word_palette      (word_palette),
        .word_hflip        (word_hflip)
    );

    pixel_serializer i_pixel_serializer (
        .clk               (clk),
        .rst               (rst),
        .line_render_start (line_render_start),
        .color_depth       (color_depth),
        .word_req          (word_req),
        .word_data         (word_data),
        .word_palette      (word_palette),
        .word_hflip        (word_hflip),
        .word_ack          (word_ack),
        .linebuf_wridx     (linebuf_wridx),
        .linebuf_wrdata    (linebuf_wrdata),
        .linebuf_wren      (linebuf_wren)
    );

endmodule

`default_nettype wire

//--- tb/tb_layer_renderer.sv
`timescale 1ns/1ps
`default_nettype none

`include "render_consts.svh"

module tb_layer_renderer;

    localparam integer rand_seed  = 32'h8ccb_e483;
    localparam integer num_lines  = 9;
    localparam integer max_cycles = num_lines * 4000;
    localparam integer line_limit = 4000;

    logic                    clk = 1'b0;
    logic                    rst = 1'b1;
    logic                    line_render_start = 1'b0;
    logic [8:0]              line_idx = '0;
    layer_pkg::color_depth_t color_depth = layer_pkg::depth_4bpp;
    logic [7:0]              map_baseaddr = '0;
    logic [7:0]              tile_baseaddr = '0;
    bus_pkg::bus_data_t      bus_rddata = '0;
    logic                    bus_ack = 1'b0;
    bus_pkg::bus_addr_t      bus_addr;
    logic                    bus_strobe;
    logic [`LB_IDX_W-1:0]    linebuf_wridx;
    layer_pkg::pixel_t       linebuf_wrdata;
    logic                    linebuf_wren;

    bus_pkg::bus_data_t mem [0:(1 << `BUS_ADDR_W)-1];
    integer fill_seed    = rand_seed;
    integer delay_seed   = rand_seed;
    integer ack_wait     = 0;
    integer req_count    = 0;
    integer cycle_count  = 0;
    integer value_errors = 0;
    integer other_errors = 0;

    always #20 clk = ~clk;

    layer_renderer i_layer_renderer (
        .clk               (clk),
        .rst               (rst),
        .line_render_start (line_render_start),
        .line_idx          (line_idx),
        .color_depth       (color_depth),
        .map_baseaddr      (map_baseaddr),
        .tile_baseaddr     (tile_baseaddr),
        .bus_rddata        (bus_rddata),
        .bus_ack           (bus_ack),
        .bus_addr          (bus_addr),
        .bus_strobe        (bus_strobe),
        .linebuf_wridx     (linebuf_wridx),
        .linebuf_wrdata    (linebuf_wrdata),
        .linebuf_wren      (linebuf_wren)
    );

    //////////////////////////////////////////////////////////////////////
    // Memory model and run limit
    //////////////////////////////////////////////////////////////////////

    // One-cycle ack 1 to 4 cycles after a strobe is seen
    always @(posedge clk) begin
        bus_ack <= 1'b0;
        if (rst) begin
            ack_wait <= 0;
        end else if (ack_wait == 1) begin
            bus_ack    <= 1'b1;
            bus_rddata <= mem[bus_addr];
            ack_wait   <= 0;
        end else if (ack_wait > 1) begin
            ack_wait <= ack_wait - 1;
        end else if (bus_strobe) begin
            ack_wait  <= 1 + ($random(delay_seed) & 3);
            req_count <= req_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Run stopped after %0d cycles, the tests did not finish", cycle_count);
            $display("Some tests failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Addresses wrap at the memory size
    function automatic bus_pkg::bus_data_t word_at(input integer addr);
        return mem[`BUS_ADDR_W'(addr)];
    endfunction

    function automatic bus_pkg::bus_addr_t map_word_addr(input logic [7:0] mb, input integer row,
                                                         input integer col);
        return `BUS_ADDR_W'(32'(mb) * 128 + row * 16 + col / 2);
    endfunction

    function automatic layer_pkg::pixel_t expected_pixel(input integer n, input logic [8:0] line,
                                                         input logic depth8,
                                                         input logic [7:0] mb,
                                                         input logic [7:0] tb);
        integer            col;
        integer            row;
        integer            x;
        integer            trow;
        integer            tile_idx;
        logic [15:0]       entry;
        bus_pkg::bus_data_t word;
        logic [7:0]        sel;
        layer_pkg::pixel_t raw;

        col      = (n / 8) % 32;
        row      = 32'(line[7:3]);
        word     = word_at(32'(mb) * 128 + (row * 32 + col) / 2);
        entry    = col[0] ? word[31:16] : word[15:0];
        tile_idx = 32'(entry[9:0]);

        // Vflip mirrors the row, hflip mirrors x over the whole tile
        trow = entry[11] ? 7 - 32'(line[2:0]) : 32'(line[2:0]);
        x    = entry[10] ? 7 - n % 8 : n % 8;

        if (depth8) begin
            // Two words per row, x/4 picks the word
            word = word_at(32'(tb) * 128 + tile_idx * 16 + trow * 2 + x / 4);
            raw  = word[8 * (x % 4) +: 8];
        end else begin
            word = word_at(32'(tb) * 128 + tile_idx * 8 + trow);
            sel  = word[8 * (x / 2) +: 8];
            raw  = {4'h0, (x % 2 == 0) ? sel[7:4] : sel[3:0]};
        end

        if (raw[7:4] == 4'h0 && raw[3:0] != 4'h0) begin
            raw[7:4] = entry[15:12];
        end
        return raw;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic fill_memory();
        integer i;
        for (i = 0; i < (1 << `BUS_ADDR_W); i++) begin
            mem[i] = $random(fill_seed);
        end
    endtask

    task automatic set_map_entry(input logic [7:0] mb, input integer row, input integer col,
                                 input logic [15:0] entry);
        bus_pkg::bus_addr_t addr;
        addr = map_word_addr(mb, row, col);
        if (col[0]) begin
            mem[addr][31:16] = entry;
        end else begin
            mem[addr][15:0] = entry;
        end
    endtask

    // Flip bits cleared, or cycled none/h/v/both along the row
    task automatic set_row_flips(input logic [7:0] mb, input logic [8:0] line, input logic mixed);
        integer             col;
        integer             row;
        bus_pkg::bus_addr_t addr;
        logic [15:0]        entry;
        row = 32'(line[7:3]);
        for (col = 0; col < 32; col++) begin
            addr         = map_word_addr(mb, row, col);
            entry        = col[0] ? mem[addr][31:16] : mem[addr][15:0];
            entry[11:10] = mixed ? col[1:0] : 2'b00;
            set_map_entry(mb, row, col, entry);
        end
    endtask

    task automatic start_line(input logic [8:0] line, input logic depth8, input logic [7:0] mb,
                              input logic [7:0] tb);
        @(posedge clk);
        line_idx          <= line;
        color_depth       <= depth8 ? layer_pkg::depth_8bpp : layer_pkg::depth_4bpp;
        map_baseaddr      <= mb;
        tile_baseaddr     <= tb;
        line_render_start <= 1'b1;
        @(posedge clk);
        line_render_start <= 1'b0;
    endtask

    task automatic wait_writes(input integer n);
        integer seen;
        integer waited;
        seen   = 0;
        waited = 0;
        while (seen < n && waited < line_limit) begin
            @(negedge clk);
            waited++;
            if (linebuf_wren) begin
                seen++;
            end
        end
        if (seen < n) begin
            $display("Only %0d of %0d line buffer writes seen", seen, n);
            other_errors++;
        end
    endtask

    // Every write checked as it comes, then a quiet stretch expected
    task automatic check_line(input string label, input logic [8:0] line, input logic depth8,
                              input logic [7:0] mb, input logic [7:0] tb);
        integer count;
        integer waited;
        integer extra;
        count  = 0;
        waited = 0;
        extra  = 0;
        while (count < `LINE_PIXELS && waited < line_limit) begin
            @(negedge clk);
            waited++;
            if (linebuf_wren) begin
                check_value("linebuf_wridx", 32'(linebuf_wridx), count);
                check_value("linebuf_wrdata", 32'(linebuf_wrdata),
                            32'(expected_pixel(count, line, depth8, mb, tb)));
                count++;
            end
        end
        if (count < `LINE_PIXELS) begin
            $display("%s: line %0d stopped after %0d of %0d pixels", label, line, count,
                     `LINE_PIXELS);
            other_errors++;
        end
        repeat (20) begin
            @(negedge clk);
            if (linebuf_wren) begin
                extra++;
            end
        end
        if (extra != 0) begin
            $display("%s: %0d writes after the end of the line", label, extra);
            other_errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_plain_4bpp();
        integer req_base;
        set_row_flips(8'h00, 9'h013, 1'b0);
        req_base = req_count;
        start_line(9'h013, 1'b0, 8'h00, 8'h40);
        check_line("plain 4bpp", 9'h013, 1'b0, 8'h00, 8'h40);
        // 40 map words and 80 tile words
        check_value("bus request count", 32'(req_count - req_base), 32'd120);
    endtask

    task automatic test_plain_8bpp();
        integer req_base;
        set_row_flips(8'h11, 9'h0c6, 1'b0);
        req_base = req_count;
        start_line(9'h0c6, 1'b1, 8'h11, 8'h80);
        check_line("plain 8bpp", 9'h0c6, 1'b1, 8'h11, 8'h80);
        check_value("bus request count", 32'(req_count - req_base), 32'd200);
    endtask

    task automatic test_flips();
        set_row_flips(8'h02, 9'h03b, 1'b1);
        start_line(9'h03b, 1'b0, 8'h02, 8'h30);
        check_line("flips 4bpp", 9'h03b, 1'b0, 8'h02, 8'h30);
        start_line(9'h03b, 1'b1, 8'h02, 8'h30);
        check_line("flips 8bpp", 9'h03b, 1'b1, 8'h02, 8'h30);
    endtask

    // Every column shows tile 9 under palettes 1 to 15, row 5 of the tile
    task automatic test_palette_wrap();
        integer col;
        for (col = 0; col < 32; col++) begin
            set_map_entry(8'h5a, 20, col, {4'(col % 15 + 1), 2'b00, 10'd9});
        end
        mem[`BUS_ADDR_W'(32'h23 * 128 + 9 * 8 + 5)]      = 32'h0f1a_3c05;
        mem[`BUS_ADDR_W'(32'h23 * 128 + 9 * 16 + 10)]    = 32'h9a0f_0500;
        mem[`BUS_ADDR_W'(32'h23 * 128 + 9 * 16 + 11)]    = 32'h01ff_1000;
        start_line(9'h1a5, 1'b0, 8'h5a, 8'h23);
        check_line("palette 4bpp", 9'h1a5, 1'b0, 8'h5a, 8'h23);
        start_line(9'h1a5, 1'b1, 8'h5a, 8'h23);
        check_line("palette 8bpp", 9'h1a5, 1'b1, 8'h5a, 8'h23);
    endtask

    task automatic test_restart();
        // Reset lands while a line is being written
        start_line(9'h077, 1'b1, 8'h02, 8'h30);
        wait_writes(50);
        @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("bus_strobe", 32'(bus_strobe), 32'd0);
        check_value("linebuf_wren", 32'(linebuf_wren), 32'd0);

        start_line(9'h077, 1'b1, 8'h02, 8'h30);
        wait_writes(100);
        // Second start abandons the line halfway
        start_line(9'h0e9, 1'b1, 8'h02, 8'h30);
        check_line("restart", 9'h0e9, 1'b1, 8'h02, 8'h30);
    endtask

    initial begin
        fill_memory();
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        test_plain_4bpp();
        test_plain_8bpp();
        test_flips();
        test_palette_wrap();
        test_restart();

        $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+hw
hw/bus_pkg.sv
hw/layer_pkg.sv
hw/tile_addr_gen.sv
hw/tile_fetcher.sv
hw/pixel_serializer.sv
hw/layer_renderer.sv
tb/tb_layer_renderer.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --timing --timescale 1ns/1ps
TOP       := tb_layer_renderer
FILELIST  := list.f
BUILD_DIR := obj_dir
PASS_MSG  := All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
